// File: tb.f
source/ppu_pkg.sv
source/square_store.sv
source/vga_timing.sv
source/square_locator.sv
source/pixel_compositor.sv
source/ppu_top.sv
sim/ppu_timing_checker.sv
sim/tb_ppu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ppu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_ppu -f tb.f -Mdir obj_dir -o tb_ppu

# a failing assertion stops the run early, the log search below decides
./obj_dir/tb_ppu > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"

// File: sim/tb_ppu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ppu;

    import ppu_pkg::*;

    // five frames with margin plus reset
    localparam int cycle_limit  = 2700000;
    localparam int update_count = 60;
    localparam int mark_count   = 40;
    localparam int max_prints   = 10;

    logic          vga_clk;
    logic          rst_n;
    logic          receive;
    logic          board;
    square_idx_t   square_update;
    square_state_e square_state;
    ship_type_e    ship_type;
    logic          square_sel;
    logic          ai;
    logic [7:0]    r;
    logic [7:0]    g;
    logic [7:0]    b;
    logic          hs;
    logic          vs;
    logic          blank_n;

    // reference copy of both boards
    square_entry_t model [2][100];

    int cycle_count   = 0;
    int tests_passed  = 0;
    int tests_failed  = 0;
    int total_errors  = 0;
    int sync_errors   = 0;
    int raster_errors = 0;
    int hs_checked    = 0;
    int vs_checked    = 0;
    int seed_dummy;

    ppu_top i_dut (
        .vga_clk       (vga_clk),
        .rst_n         (rst_n),
        .receive       (receive),
        .board         (board),
        .square_update (square_update),
        .square_state  (square_state),
        .ship_type     (ship_type),
        .square_sel    (square_sel),
        .ai            (ai),
        .r             (r),
        .g             (g),
        .b             (b),
        .hs            (hs),
        .vs            (vs),
        .blank_n       (blank_n)
    );

    bind vga_timing ppu_timing_checker i_timing_checker (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .h_cnt   (h_cnt),
        .v_cnt   (v_cnt),
        .r       (r),
        .g       (g),
        .b       (b),
        .hs      (hs),
        .vs      (vs),
        .blank_n (blank_n)
    );

    initial vga_clk = 1'b0;
    always #5 vga_clk = ~vga_clk;

    always @(posedge vga_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // colour of one active pixel from the drawing rules
    function automatic rgb332_t expected_pixel(input int x, input int y);
        int            sq;
        int            span;
        int            bd;
        int            dx;
        int            dy;
        square_entry_t e;
        rgb332_t       c;
        sq   = int'(square_size);
        span = sq * int'(grid_squares);
        dx   = 0;
        dy   = y - int'(board_row0);
        if (x >= int'(board0_col0) && x < int'(board0_col0) + span) begin
            bd = 0;
            dx = x - int'(board0_col0);
        end else if (x >= int'(board1_col0) && x < int'(board1_col0) + span) begin
            bd = 1;
            dx = x - int'(board1_col0);
        end else begin
            bd = -1;
        end
        if (bd < 0 || dy < 0 || dy >= span) begin
            return water_color;
        end
        if (dx % sq == 0 || dy % sq == 0) begin
            return grid_color;
        end
        e = model[bd][(dy / sq) * int'(grid_squares) + dx / sq];
        case (e.state)
            st_empty: c = water_color;
            st_miss:  c = miss_color;
            st_hit:   c = hit_color;
            default: begin
                case (e.ship)
                    ship_2:  c = ship_color_2;
                    ship_3:  c = ship_color_3;
                    ship_4:  c = ship_color_4;
                    default: c = ship_color_5;
                endcase
            end
        endcase
        if (e.ai) begin
            c = ai_color;
        end
        if (e.sel) begin
            c = ~c;
        end
        return c;
    endfunction

    task automatic compare_pixel(input rgb332_t got, input rgb332_t exp, input logic low_clear,
                                 input int x, input int y, inout int errs);
        if (got !== exp || low_clear !== 1'b1) begin
            errs++;
            if (errs <= max_prints) begin
                $display("[ERROR] %0t ns: pixel (%0d,%0d) got %b (low bits clear %b), expected %b",
                         $time, x, y, got, low_clear, exp);
            end
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp,
                                 inout int errs);
        if (got != exp) begin
            errs++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_idle_outputs(inout int errs);
        compare_count("blank_n", int'(blank_n), 0, errs);
        compare_count("hs", int'(hs), 1, errs);
        compare_count("vs", int'(vs), 1, errs);
        compare_count("rgb", int'({r, g, b}), 0, errs);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            total_errors += errs;
            $display("test %s: fail with %0d errors", name, errs);
        end
    endtask

    // checks the next full frame and returns once its vs pulse starts
    task automatic check_frame(inout int errs);
        int run;
        int lines;
        @(negedge vga_clk);
        while (vs !== 1'b0) @(negedge vga_clk);
        while (vs !== 1'b1) @(negedge vga_clk);
        run   = 0;
        lines = 0;
        while (vs === 1'b1) begin
            @(negedge vga_clk);
            if (blank_n === 1'b1) begin
                compare_pixel({r[7:5], g[7:5], b[7:6]}, expected_pixel(run, lines),
                              (r[4:0] == 5'd0 && g[4:0] == 5'd0 && b[5:0] == 6'd0),
                              run, lines, errs);
                run++;
            end else if (run > 0) begin
                compare_count("active pixels in line", run, int'(h_active), raster_errors);
                lines++;
                run = 0;
            end
        end
        compare_count("active lines in frame", lines, int'(v_active), raster_errors);
    endtask

    // random writes during the vs pulse mirrored into the model
    task automatic issue_updates(input int count, input logic marks);
        int            n;
        logic          bd;
        square_idx_t   sq;
        square_entry_t e;
        @(negedge vga_clk);
        while (vs !== 1'b0) @(negedge vga_clk);
        for (n = 0; n < count; n++) begin
            bd      = ($urandom_range(0, 1) != 0);
            e.state = square_state_e'($urandom_range(0, 3));
            e.ship  = ship_type_e'($urandom_range(0, 3));
            e.sel   = 1'b0;
            e.ai    = 1'b0;
            if (marks) begin
                sq    = square_idx_t'($urandom_range(0, 99));
                e.sel = ($urandom_range(0, 1) != 0);
                e.ai  = ($urandom_range(0, 1) != 0) || !e.sel;
            end else if (n % 8 == 7) begin
                sq = square_idx_t'($urandom_range(100, 127));
            end else begin
                sq = square_idx_t'($urandom_range(0, 127));
            end
            @(posedge vga_clk);
            receive       <= 1'b1;
            board         <= bd;
            square_update <= sq;
            square_state  <= e.state;
            ship_type     <= e.ship;
            square_sel    <= e.sel;
            ai            <= e.ai;
            if (sq < 7'd100) begin
                model[bd][sq] = e;
            end
        end
        @(posedge vga_clk);
        receive <= 1'b0;
    endtask

    // sync period monitor
    logic hs_prev;
    logic vs_prev;
    logic hs_seen;
    logic vs_seen;
    int   hs_period;
    int   lines_since_vs;

    always @(negedge vga_clk) begin
        if (!rst_n) begin
            hs_prev        = 1'b1;
            vs_prev        = 1'b1;
            hs_seen        = 1'b0;
            vs_seen        = 1'b0;
            hs_period      = 0;
            lines_since_vs = 0;
        end else begin
            hs_period++;
            if (hs_prev && !hs) begin
                if (hs_seen) begin
                    compare_count("cycles between hs falls", hs_period, int'(h_total), sync_errors);
                    hs_checked++;
                end
                hs_seen   = 1'b1;
                hs_period = 0;
                lines_since_vs++;
            end
            if (vs_prev && !vs) begin
                if (vs_seen) begin
                    compare_count("lines between vs falls", lines_since_vs, int'(v_total),
                                  sync_errors);
                    vs_checked++;
                end
                vs_seen        = 1'b1;
                lines_since_vs = 0;
            end
            hs_prev = hs;
            vs_prev = vs;
        end
    end

    initial begin
        int errs;
        seed_dummy    = $urandom(32'hf3e2b59e);
        rst_n         = 1'b0;
        receive       = 1'b0;
        board         = 1'b0;
        square_update = '0;
        square_state  = st_empty;
        ship_type     = ship_2;
        square_sel    = 1'b0;
        ai            = 1'b0;
        for (int bd = 0; bd < 2; bd++) begin
            for (int sq = 0; sq < 100; sq++) begin
                model[bd][sq] = '0;
            end
        end

        errs = 0;
        repeat (5) begin
            @(negedge vga_clk);
            check_idle_outputs(errs);
        end
        @(posedge vga_clk);
        rst_n <= 1'b1;
        @(negedge vga_clk);
        check_idle_outputs(errs);
        report_test("1 outputs after reset", errs);

        errs = 0;
        check_frame(errs);
        report_test("3 empty boards", errs);

        errs = 0;
        issue_updates(update_count, 1'b0);
        check_frame(errs);
        report_test("4 random square updates", errs);

        errs = 0;
        issue_updates(mark_count, 1'b1);
        check_frame(errs);
        report_test("5 ai and sel marks", errs);

        // let the monitor finish the vs fall seen on the last negedge
        @(posedge vga_clk);

        // sync periods and raster counts gathered over the whole run
        errs = sync_errors + raster_errors;
        compare_count("hs periods measured", int'(hs_checked > 0), 1, errs);
        compare_count("vs periods measured", int'(vs_checked >= 2), 1, errs);
        report_test("2 sync timing", errs);

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ppu_timing_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_timing_checker (
    input wire logic            vga_clk,
    input wire logic            rst_n,
    input wire ppu_pkg::coord_t h_cnt,
    input wire ppu_pkg::coord_t v_cnt,
    input wire logic [7:0]      r,
    input wire logic [7:0]      g,
    input wire logic [7:0]      b,
    input wire logic            hs,
    input wire logic            vs,
    input wire logic            blank_n
);

    import ppu_pkg::*;

    // cycles hs has been low so far in the current pulse
    logic [9:0] hs_low_len;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_low_len <= '0;
        end else if (!hs) begin
            hs_low_len <= hs_low_len + 10'd1;
        end else begin
            hs_low_len <= '0;
        end
    end

    a_hs_width: assert property (@(posedge vga_clk) disable iff (!rst_n)
        $rose(hs) |-> (hs_low_len == h_sync))
        else $error("hs pulse was %0d cycles long", hs_low_len);

    a_hs_no_overrun: assert property (@(posedge vga_clk) disable iff (!rst_n)
        !hs |-> (hs_low_len < h_sync))
        else $error("hs stayed low past the sync width");

    a_black_in_blank: assert property (@(posedge vga_clk) disable iff (!rst_n)
        !blank_n |-> (r == 8'd0 && g == 8'd0 && b == 8'd0))
        else $error("colour driven during blanking");

    // outputs trail the counters by two edges, hence column 2
    a_vs_start: assert property (@(posedge vga_clk) disable iff (!rst_n)
        $fell(vs) |-> (v_cnt == v_active + v_front && h_cnt == 10'd2))
        else $error("vs fell at line %0d column %0d", v_cnt, h_cnt);

    a_vs_end: assert property (@(posedge vga_clk) disable iff (!rst_n)
        $rose(vs) |-> (v_cnt == v_active + v_front + v_sync && h_cnt == 10'd2))
        else $error("vs rose at line %0d column %0d", v_cnt, h_cnt);

endmodule

`default_nettype wire

// File: source/ppu_top.sv
`timescale 1ns/1ns
`default_nettype none

module ppu_top (
    input  wire logic                  vga_clk,
    input  wire logic                  rst_n,
    input  wire logic                  receive,
    input  wire logic                  board,
    input  wire ppu_pkg::square_idx_t  square_update,
    input  wire ppu_pkg::square_state_e square_state,
    input  wire ppu_pkg::ship_type_e   ship_type,
    input  wire logic                  square_sel,
    input  wire logic                  ai,
    output logic [7:0]                 r,
    output logic [7:0]                 g,
    output logic [7:0]                 b,
    output logic                       hs,
    output logic                       vs,
    output logic                       blank_n
);

    import ppu_pkg::*;

    coord_t        next_x;
    coord_t        next_y;
    logic          on_board;
    logic          loc_board;
    square_idx_t   loc_square;
    logic [3:0]    off_x;
    logic [3:0]    off_y;
    square_entry_t entry;
    rgb332_t       pixel_rgb;

    square_store i_store (
        .vga_clk       (vga_clk),
        .rst_n         (rst_n),
        .receive       (receive),
        .board         (board),
        .square_update (square_update),
        .square_state  (square_state),
        .ship_type     (ship_type),
        .square_sel    (square_sel),
        .ai            (ai),
        .read_board    (loc_board),
        .read_square   (loc_square),
        .read_entry    (entry)
    );

    // location lags next_x/next_y by one edge
    square_locator i_locator (
        .vga_clk    (vga_clk),
        .rst_n      (rst_n),
        .next_x     (next_x),
        .next_y     (next_y),
        .on_board   (on_board),
        .loc_board  (loc_board),
        .loc_square (loc_square),
        .off_x      (off_x),
        .off_y      (off_y)
    );

    pixel_compositor i_compositor (
        .on_board  (on_board),
        .entry     (entry),
        .off_x     (off_x),
        .off_y     (off_y),
        .pixel_rgb (pixel_rgb)
    );

    vga_timing i_timing (
        .vga_clk   (vga_clk),
        .rst_n     (rst_n),
        .pixel_rgb (pixel_rgb),
        .next_x    (next_x),
        .next_y    (next_y),
        .r         (r),
        .g         (g),
        .b         (b),
        .hs        (hs),
        .vs        (vs),
        .blank_n   (blank_n)
    );

endmodule

`default_nettype wire

// File: source/pixel_compositor.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_compositor (
    input  wire logic                  on_board,
    input  wire ppu_pkg::square_entry_t entry,
    input  wire logic [3:0]            off_x,
    input  wire logic [3:0]            off_y,
    output ppu_pkg::rgb332_t           pixel_rgb
);

    import ppu_pkg::*;

    logic    on_grid;
    rgb332_t ship_rgb;
    rgb332_t state_rgb;
    rgb332_t marked_rgb;
    rgb332_t interior_rgb;

    // first row and column of every square carry the grid line
    assign on_grid = (off_x == 4'd0) || (off_y == 4'd0);

    always_comb begin
        case (entry.ship)
            ship_2:  ship_rgb = ship_color_2;
            ship_3:  ship_rgb = ship_color_3;
            ship_4:  ship_rgb = ship_color_4;
            ship_5:  ship_rgb = ship_color_5;
            default: ship_rgb = ship_color_2;
        endcase
    end

    always_comb begin
        case (entry.state)
            st_empty: state_rgb = water_color;
            st_miss:  state_rgb = miss_color;
            st_hit:   state_rgb = hit_color;
            st_ship:  state_rgb = ship_rgb;
            default:  state_rgb = water_color;
        endcase
    end

    // ai mark first, selection inverts on top of it
    assign marked_rgb   = entry.ai ? ai_color : state_rgb;
    assign interior_rgb = entry.sel ? ~marked_rgb : marked_rgb;

    always_comb begin
        if (!on_board) begin
            pixel_rgb = water_color;
        end else if (on_grid) begin
            pixel_rgb = grid_color;
        end else begin
            pixel_rgb = interior_rgb;
        end
    end

endmodule

`default_nettype wire

// File: source/square_locator.sv
`timescale 1ns/1ns
`default_nettype none

module square_locator (
    input  wire logic            vga_clk,
    input  wire logic            rst_n,
    input  wire ppu_pkg::coord_t next_x,
    input  wire ppu_pkg::coord_t next_y,
    output logic                 on_board,
    output logic                 loc_board,
    output ppu_pkg::square_idx_t loc_square,
    output logic [3:0]           off_x,
    output logic [3:0]           off_y
);

    import ppu_pkg::*;

    logic        in_rows;
    logic        in_b0;
    logic        in_b1;
    coord_t      dx;
    coord_t      dy;
    logic [3:0]  sq_col;
    logic [3:0]  sq_row;
    square_idx_t sq_idx;

    // both grids share the same rows
    assign in_rows = (next_y >= board_row0) &&
                     (next_y <  board_row0 + square_size * grid_squares);
    assign in_b0   = in_rows && (next_x >= board0_col0) &&
                     (next_x < board0_col0 + square_size * grid_squares);
    assign in_b1   = in_rows && (next_x >= board1_col0) &&
                     (next_x < board1_col0 + square_size * grid_squares);

    // offset from the origin of whichever grid we are in
    assign dx = next_x - (in_b1 ? board1_col0 : board0_col0);
    assign dy = next_y - board_row0;

    // 16 pixel squares, so the column and row are bits 7:4
    assign sq_col = dx[7:4];
    assign sq_row = dy[7:4];
    assign sq_idx = {3'b0, sq_row} * square_idx_t'(grid_squares) + {3'b0, sq_col};

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            on_board   <= 1'b0;
            loc_board  <= 1'b0;
            loc_square <= '0;
            off_x      <= '0;
            off_y      <= '0;
        end else begin
            on_board   <= in_b0 || in_b1;
            loc_board  <= in_b1;
            // keep the read address in range off the grids
            loc_square <= (in_b0 || in_b1) ? sq_idx : '0;
            off_x      <= dx[3:0];
            off_y      <= dy[3:0];
        end
    end

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  wire logic             vga_clk,
    input  wire logic             rst_n,
    input  wire ppu_pkg::rgb332_t pixel_rgb,
    output ppu_pkg::coord_t       next_x,
    output ppu_pkg::coord_t       next_y,
    output logic [7:0]            r,
    output logic [7:0]            g,
    output logic [7:0]            b,
    output logic                  hs,
    output logic                  vs,
    output logic                  blank_n
);

    import ppu_pkg::*;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   line_end;
    logic   frame_end;
    logic   active;
    logic   hs_raw;
    logic   vs_raw;

    // first stage, lines up with the locator register
    logic   active_d;
    logic   hs_d;
    logic   vs_d;

    assign line_end  = (h_cnt == h_total - 10'd1);
    assign frame_end = (v_cnt == v_total - 10'd1);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    assign next_x = h_cnt;
    assign next_y = v_cnt;

    assign active = (h_cnt < h_active) && (v_cnt < v_active);

    // sync pulses are active low
    assign hs_raw = !((h_cnt >= h_active + h_front) &&
                      (h_cnt <  h_active + h_front + h_sync));
    assign vs_raw = !((v_cnt >= v_active + v_front) &&
                      (v_cnt <  v_active + v_front + v_sync));

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            hs_d     <= 1'b1;
            vs_d     <= 1'b1;
        end else begin
            active_d <= active;
            hs_d     <= hs_raw;
            vs_d     <= vs_raw;
        end
    end

    // output stage, black outside the active window
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            r       <= '0;
            g       <= '0;
            b       <= '0;
            hs      <= 1'b1;
            vs      <= 1'b1;
            blank_n <= 1'b0;
        end else begin
            r       <= active_d ? {pixel_rgb[7:5], 5'b0} : 8'd0;
            g       <= active_d ? {pixel_rgb[4:2], 5'b0} : 8'd0;
            b       <= active_d ? {pixel_rgb[1:0], 6'b0} : 8'd0;
            hs      <= hs_d;
            vs      <= vs_d;
            blank_n <= active_d;
        end
    end

endmodule

`default_nettype wire

// File: source/square_store.sv
`timescale 1ns/1ns
`default_nettype none

module square_store (
    input  wire logic                  vga_clk,
    input  wire logic                  rst_n,
    input  wire logic                  receive,
    input  wire logic                  board,
    input  wire ppu_pkg::square_idx_t  square_update,
    input  wire ppu_pkg::square_state_e square_state,
    input  wire ppu_pkg::ship_type_e   ship_type,
    input  wire logic                  square_sel,
    input  wire logic                  ai,
    input  wire logic                  read_board,
    input  wire ppu_pkg::square_idx_t  read_square,
    output ppu_pkg::square_entry_t     read_entry
);

    import ppu_pkg::*;

    // one bank of entries per board
    square_entry_t bank [2][grid_squares * grid_squares];

    square_entry_t new_entry;
    logic          write_en;

    assign new_entry.state = square_state;
    assign new_entry.ship  = ship_type;
    assign new_entry.sel   = square_sel;
    assign new_entry.ai    = ai;

    // squares past the last one are dropped
    assign write_en = receive && (square_update < grid_squares * grid_squares);

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            // both boards start empty, nothing selected
            bank <= '{default: '0};
        end else if (write_en) begin
            bank[board][square_update] <= new_entry;
        end
    end

    // locator only ever presents squares 0 to 99
    assign read_entry = bank[read_board][read_square];

endmodule

`default_nettype wire

// File: source/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // pixel coordinate, wide enough for the full 800x525 raster
    typedef logic [9:0] coord_t;

    // horizontal timing in pixels
    localparam coord_t h_active = 10'd640;
    localparam coord_t h_front  = 10'd16;
    localparam coord_t h_sync   = 10'd96;
    localparam coord_t h_back   = 10'd48;
    localparam coord_t h_total  = h_active + h_front + h_sync + h_back;

    // vertical timing in lines
    localparam coord_t v_active = 10'd480;
    localparam coord_t v_front  = 10'd10;
    localparam coord_t v_sync   = 10'd2;
    localparam coord_t v_back   = 10'd33;
    localparam coord_t v_total  = v_active + v_front + v_sync + v_back;

    // board geometry, origins are the top left grid pixel
    localparam coord_t square_size  = 10'd16;
    localparam coord_t grid_squares = 10'd10;
    localparam coord_t board0_col0  = 10'd112;
    localparam coord_t board1_col0  = 10'd390;
    localparam coord_t board_row0   = 10'd199;

    // square number on one board, 0 to 99
    typedef logic [6:0] square_idx_t;

    typedef enum logic [1:0] {
        st_empty = 2'b00,
        st_miss  = 2'b01,
        st_hit   = 2'b10,
        st_ship  = 2'b11
    } square_state_e;

    typedef enum logic [1:0] {
        ship_2 = 2'b00,
        ship_3 = 2'b01,
        ship_4 = 2'b10,
        ship_5 = 2'b11
    } ship_type_e;

    typedef struct packed {
        square_state_e state;
        ship_type_e    ship;
        logic          sel;
        logic          ai;
    } square_entry_t;

    // rrr_ggg_bb
    typedef logic [7:0] rgb332_t;

    localparam rgb332_t water_color  = 8'b000_010_10;
    localparam rgb332_t grid_color   = 8'b110_110_11;
    localparam rgb332_t miss_color   = 8'b111_111_11;
    localparam rgb332_t hit_color    = 8'b111_000_00;
    localparam rgb332_t ship_color_2 = 8'b011_011_01;
    localparam rgb332_t ship_color_3 = 8'b100_100_10;
    localparam rgb332_t ship_color_4 = 8'b010_010_01;
    localparam rgb332_t ship_color_5 = 8'b101_011_01;
    localparam rgb332_t ai_color     = 8'b000_111_00;

endpackage

`default_nettype wire
